// ==== logic/mipsIsaPkg.sv ====
package mipsIsaPkg;

	// field widths of the MIPS32 instruction word
	localparam int WORD_W     = 32;
	localparam int REG_ADDR_W = 5;
	localparam int OP_W       = 6;
	localparam int FUNCT_W    = 6;
	localparam int SHAMT_W    = 5;
	localparam int IMM_W      = 16;
	localparam int REG_COUNT  = 1 << REG_ADDR_W; // 32 architectural registers

	typedef logic [WORD_W-1:0]     word_t;    // data and address word
	typedef logic [REG_ADDR_W-1:0] regAddr_t; // register index

	// primary opcodes, bits 31:26
	typedef enum logic [OP_W-1:0] {
		opRType = 6'h00, // funct field selects the operation
		opBeq   = 6'h04,
		opAddi  = 6'h08,
		opLw    = 6'h23,
		opSw    = 6'h2b
	} opCode_e;

	// R-type function codes, bits 5:0
	typedef enum logic [FUNCT_W-1:0] {
		fnAdd = 6'h20,
		fnSub = 6'h22,
		fnAnd = 6'h24,
		fnOr  = 6'h25,
		fnSlt = 6'h2a
	} funct_e;

	// R-type view of the instruction word, msb first
	// I-type immediate overlaps rd, shamt and funct, taken from the low bits instead
	typedef struct packed {
		opCode_e                op;
		regAddr_t               rs;    // first source
		regAddr_t               rt;    // second source or I-type destination
		regAddr_t               rd;    // R-type destination
		logic [SHAMT_W-1:0]     shamt; // no shifts, ignored
		funct_e                 funct;
	} instrFields_t;

endpackage

// ==== logic/mipsCtrlPkg.sv ====
package mipsCtrlPkg;

	// operations the ALU can do, encoding matches the decode table
	typedef enum logic [2:0] {
		aluAdd = 3'd0,
		aluSub = 3'd1,
		aluAnd = 3'd2,
		aluOr  = 3'd3,
		aluSlt = 3'd4
	} aluOp_e;

	// datapath control for one instruction, 10 bits
	typedef struct packed {
		logic   regDst;     // 1 = write rd, 0 = write rt
		logic   branch;     // beq
		logic   memReadEn;  // lw
		logic   memToReg;   // writeback from memory instead of ALU
		logic   memWriteEn; // sw
		logic   regWriteEn;
		logic   aluSrc;     // 1 = immediate as second operand
		aluOp_e aluOp;
	} ctrl_t;

	// no-op control word, nothing written and pc just advances
	localparam ctrl_t CTRL_NOP = '{regDst: 1'b0, branch: 1'b0, memReadEn: 1'b0,
		memToReg: 1'b0, memWriteEn: 1'b0, regWriteEn: 1'b0, aluSrc: 1'b0, aluOp: aluAdd};

endpackage

// ==== logic/controlUnit.sv ====
`timescale 1ns/1ps

module controlUnit (
	input  mipsIsaPkg::opCode_e opCode,
	input  mipsIsaPkg::funct_e  funct,
	output mipsCtrlPkg::ctrl_t  ctrl
);

	import mipsIsaPkg::*;
	import mipsCtrlPkg::*;

	always_comb begin
		ctrl = CTRL_NOP; // everything off unless the opcode says otherwise

		case (opCode)
			opRType: begin
				ctrl.regDst     = 1'b1; // destination is rd
				ctrl.regWriteEn = 1'b1; // result goes back to rd
				ctrl.aluSrc     = 1'b0; // both operands from the register file

				case (funct)
					fnAdd: ctrl.aluOp = aluAdd;
					fnSub: ctrl.aluOp = aluSub;
					fnAnd: ctrl.aluOp = aluAnd;
					fnOr:  ctrl.aluOp = aluOr;
					fnSlt: ctrl.aluOp = aluSlt; // signed compare
					default: begin
						ctrl.regWriteEn = 1'b0; // unknown funct acts as a no-op
					end
				endcase
			end

			opAddi: begin
				ctrl.regDst     = 1'b0; // destination is rt
				ctrl.aluSrc     = 1'b1; // sign-extended immediate
				ctrl.aluOp      = aluAdd;
				ctrl.regWriteEn = 1'b1;
			end

			opLw: begin
				ctrl.regDst     = 1'b0; // load into rt
				ctrl.aluSrc     = 1'b1; // base plus offset
				ctrl.aluOp      = aluAdd;
				ctrl.memReadEn  = 1'b1;
				ctrl.memToReg   = 1'b1; // writeback from data memory
				ctrl.regWriteEn = 1'b1;
			end

			opSw: begin
				ctrl.aluSrc     = 1'b1; // base plus offset
				ctrl.aluOp      = aluAdd;
				ctrl.memWriteEn = 1'b1; // rt goes to memory
				ctrl.regWriteEn = 1'b0;
			end

			opBeq: begin
				ctrl.branch     = 1'b1;
				ctrl.aluSrc     = 1'b0; // compare rs against rt
				ctrl.aluOp      = aluSub; // zero flag means equal
				ctrl.regWriteEn = 1'b0;
			end

			default: begin
				ctrl = CTRL_NOP; // unknown opcode, no branch and no writes
			end
		endcase
	end

endmodule

// ==== logic/aluUnit.sv ====
`timescale 1ns/1ps

module aluUnit (
	input  mipsCtrlPkg::aluOp_e op,
	input  mipsIsaPkg::word_t   a,
	input  mipsIsaPkg::word_t   b,
	output mipsIsaPkg::word_t   result,
	output logic                zero
);

	import mipsCtrlPkg::*;

	always_comb begin
		result = '0;

		case (op)
			aluAdd: result = a + b; // wraps, no overflow trap
			aluSub: result = a - b;
			aluAnd: result = a & b;
			aluOr:  result = a | b;
			aluSlt: begin
				result[0] = ($signed(a) < $signed(b)); // 1 or 0, upper bits stay clear
			end
			default: begin
				result = '0; // unused encodings
			end
		endcase
	end

	assign zero = (result == '0); // used by beq

endmodule

// ==== logic/regFile.sv ====
`timescale 1ns/1ps

module regFile (
	input  logic                clk,
	input  logic                reset,
	input  mipsIsaPkg::regAddr_t raddrA,
	input  mipsIsaPkg::regAddr_t raddrB,
	output mipsIsaPkg::word_t    rdataA,
	output mipsIsaPkg::word_t    rdataB,
	input  logic                we,
	input  mipsIsaPkg::regAddr_t waddr,
	input  mipsIsaPkg::word_t    wdata
);

	import mipsIsaPkg::*;

	word_t regs [REG_COUNT]; // regs[0] is never written

	always_ff @(posedge clk) begin
		if (reset) begin
			regs <= '{default: '0}; // whole file clears
		end else if (we && (waddr != '0)) begin
			regs[waddr] <= wdata; // writes to r0 dropped
		end
	end

	// reads are combinational, a write shows up after the edge
	assign rdataA = regs[raddrA];
	assign rdataB = regs[raddrB];

	// r0 must stay zero whatever the core tried to write earlier
	assert property (@(posedge clk) disable iff (reset) regs[0] == '0)
		else $error("regFile: r0 no longer reads zero");

endmodule

// ==== logic/dataMemory.sv ====
`timescale 1ns/1ps

module dataMemory #(
	parameter int unsigned DATA_WORDS = 256
) (
	input  logic              clk,
	input  logic              reset,
	input  logic              we,
	input  logic              re,
	input  mipsIsaPkg::word_t addr,
	input  mipsIsaPkg::word_t wdata,
	output mipsIsaPkg::word_t rdata
);

	import mipsIsaPkg::*;

	localparam int ADDR_BITS = $clog2(DATA_WORDS); // index width

	if (DATA_WORDS != (1 << ADDR_BITS)) begin : gDepthCheck
		$error("dataMemory: DATA_WORDS must be a power of two");
	end

	word_t                mem [DATA_WORDS];
	logic [ADDR_BITS-1:0] index;

	assign index = addr[2 +: ADDR_BITS]; // byte offset dropped, wraps modulo depth

	always_ff @(posedge clk) begin
		if (reset) begin
			mem <= '{default: '0};
		end else if (we) begin
			mem[index] <= wdata;
		end
	end

	assign rdata = re ? mem[index] : '0; // quiet unless a load is in progress

	// a single-cycle instruction is either a load or a store, never both
	assert property (@(posedge clk) disable iff (reset) !(we && re))
		else $error("dataMemory: read and write enabled together");

endmodule

// ==== logic/mipsCore.sv ====
`timescale 1ns/1ps

module mipsCore #(
	parameter int unsigned DATA_WORDS = 256
) (
	input  logic                 clk,
	input  logic                 reset,
	output mipsIsaPkg::word_t    pc,
	input  mipsIsaPkg::word_t    instr,
	output logic                 regWe,
	output mipsIsaPkg::regAddr_t regWaddr,
	output mipsIsaPkg::word_t    regWdata,
	output logic                 memWe,
	output mipsIsaPkg::word_t    memWaddr,
	output mipsIsaPkg::word_t    memWdata
);

	import mipsIsaPkg::*;
	import mipsCtrlPkg::*;

	instrFields_t fields;
	ctrl_t        ctrl;

	word_t    pcReg;
	word_t    pcPlus4;
	word_t    branchTarget;
	word_t    pcNext;
	word_t    immExt;
	word_t    rdataA;
	word_t    rdataB;
	word_t    aluB;
	word_t    aluResult;
	word_t    memRdata;
	logic     aluZero;
	logic     takeBranch;

	assign fields = instrFields_t'(instr); // split the fetched word

	// sign extension of the 16-bit immediate
	assign immExt = {{(WORD_W - IMM_W){instr[IMM_W-1]}}, instr[IMM_W-1:0]};

	controlUnit controlUnit_i (
		.opCode (fields.op),
		.funct  (fields.funct),
		.ctrl   (ctrl)
	);

	regFile regFile_i (
		.clk    (clk),
		.reset  (reset),
		.raddrA (fields.rs),
		.raddrB (fields.rt),
		.rdataA (rdataA),
		.rdataB (rdataB),
		.we     (regWe),
		.waddr  (regWaddr),
		.wdata  (regWdata)
	);

	assign aluB = ctrl.aluSrc ? immExt : rdataB; // immediate or rt

	aluUnit aluUnit_i (
		.op     (ctrl.aluOp),
		.a      (rdataA),
		.b      (aluB),
		.result (aluResult),
		.zero   (aluZero)
	);

	dataMemory #(
		.DATA_WORDS (DATA_WORDS)
	) dataMemory_i (
		.clk    (clk),
		.reset  (reset),
		.we     (memWe),
		.re     (ctrl.memReadEn),
		.addr   (aluResult),
		.wdata  (rdataB),
		.rdata  (memRdata)
	);

	// writeback path, also the observation ports
	assign regWe    = ctrl.regWriteEn & ~reset; // nothing retires during reset
	assign regWaddr = ctrl.regDst ? fields.rd : fields.rt;
	assign regWdata = ctrl.memToReg ? memRdata : aluResult;

	assign memWe    = ctrl.memWriteEn & ~reset;
	assign memWaddr = aluResult; // byte address, low bits ignored by memory
	assign memWdata = rdataB;

	// next pc
	assign pcPlus4      = pcReg + 32'd4;
	assign branchTarget = pcPlus4 + {immExt[WORD_W-3:0], 2'b00}; // word offset
	assign takeBranch   = ctrl.branch & aluZero; // beq with equal operands
	assign pcNext       = takeBranch ? branchTarget : pcPlus4;

	always_ff @(posedge clk) begin
		if (reset) begin
			pcReg <= '0;
		end else begin
			pcReg <= pcNext; // one instruction per clock
		end
	end

	assign pc = reset ? '0 : pcReg; // fetch from 0 while held in reset

	// a store never writes the register file
	assert property (@(posedge clk) disable iff (reset) !(ctrl.memWriteEn && ctrl.regWriteEn))
		else $error("mipsCore: memory and register write both set");

endmodule

// ==== bench/mipsModel.sv ====
package mipsModel;

	import mipsIsaPkg::*;

	// MIPS32 encodings taken from the opcode map
	localparam logic [5:0] OP_SPECIAL = 6'h00; // funct field holds the operation
	localparam logic [5:0] OP_BEQ     = 6'h04;
	localparam logic [5:0] OP_ADDI    = 6'h08;
	localparam logic [5:0] OP_LW      = 6'h23;
	localparam logic [5:0] OP_SW      = 6'h2b;
	localparam logic [5:0] FN_ADD     = 6'h20;
	localparam logic [5:0] FN_SUB     = 6'h22;
	localparam logic [5:0] FN_AND     = 6'h24;
	localparam logic [5:0] FN_OR      = 6'h25;
	localparam logic [5:0] FN_SLT     = 6'h2a;

	// what one instruction should show on the observation ports
	typedef struct packed {
		word_t    nextPc;
		logic     regWe;
		regAddr_t regWaddr;
		word_t    regWdata;
		logic     memWe;
		word_t    memWaddr; // full byte address as computed
		word_t    memWdata;
	} prediction_t;

	word_t archRegs [REG_COUNT]; // architectural register file
	word_t archMem [];           // sized to the DUT memory depth
	word_t archPc;

	function automatic void resetState(int unsigned words);
		archMem = new[words];
		foreach (archMem[i]) begin
			archMem[i] = '0;
		end
		foreach (archRegs[i]) begin
			archRegs[i] = '0;
		end
		archPc = '0;
	endfunction

	// run one instruction on the architectural state and report its effects
	function automatic prediction_t execute(word_t instr);
		prediction_t p;
		logic [5:0]  op;
		logic [5:0]  fn;
		regAddr_t    rs;
		regAddr_t    rt;
		regAddr_t    rd;
		word_t       a;
		word_t       b;
		word_t       imm;
		word_t       addr;
		int unsigned index;
		op  = instr[31:26];
		rs  = instr[25:21];
		rt  = instr[20:16];
		rd  = instr[15:11];
		fn  = instr[5:0];
		imm = {{16{instr[15]}}, instr[15:0]}; // sign extended
		a   = archRegs[rs];
		b   = archRegs[rt];
		addr  = a + imm;
		index = (addr >> 2) % archMem.size(); // word index, wraps with the depth
		p = '0;
		p.nextPc = archPc + 32'd4;
		case (op)
			OP_SPECIAL: begin
				p.regWe    = 1'b1;
				p.regWaddr = rd;
				case (fn)
					FN_ADD: p.regWdata = a + b;
					FN_SUB: p.regWdata = a - b;
					FN_AND: p.regWdata = a & b;
					FN_OR:  p.regWdata = a | b;
					FN_SLT: p.regWdata = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					default: p.regWe = 1'b0; // unknown funct retires as a no-op
				endcase
			end
			OP_ADDI: begin
				p.regWe    = 1'b1;
				p.regWaddr = rt;
				p.regWdata = a + imm;
			end
			OP_LW: begin
				p.regWe    = 1'b1;
				p.regWaddr = rt;
				p.regWdata = archMem[index];
			end
			OP_SW: begin
				p.memWe    = 1'b1;
				p.memWaddr = addr;
				p.memWdata = b;
			end
			OP_BEQ: begin
				if (a == b) begin
					p.nextPc = archPc + 32'd4 + (imm << 2);
				end
			end
			default: ; // unknown opcode, pc just advances
		endcase
		if (p.regWe && (p.regWaddr != '0)) begin
			archRegs[p.regWaddr] = p.regWdata; // r0 stays zero
		end
		if (p.memWe) begin
			archMem[index] = p.memWdata;
		end
		archPc = p.nextPc;
		return p;
	endfunction

endpackage

// ==== bench/coreBench.sv ====
`timescale 1ns/1ps

module coreBench;

	import mipsIsaPkg::*;
	import mipsModel::*;

	localparam int unsigned DATA_WORDS     = 256;
	localparam int          PROG_LEN       = 400;
	localparam int          RUN_LENGTH     = 2 * PROG_LEN; // instructions retired per run
	localparam int          RESET_CYCLES   = 8;
	localparam int          TIMEOUT_CYCLES = 2 * PROG_LEN + RESET_CYCLES + 20;
	localparam int          HALF_PERIOD    = 10;
	localparam int          DRIVE_DELAY    = 1;
	localparam int          CHECK_AT       = 2 * HALF_PERIOD - DRIVE_DELAY - 2; // 2 ns before edge
	localparam int unsigned SEED           = 79979;

	logic     clk;
	logic     reset;
	word_t    pc;
	word_t    instr;
	logic     regWe;
	regAddr_t regWaddr;
	word_t    regWdata;
	logic     memWe;
	word_t    memWaddr;
	word_t    memWdata;

	word_t       progMem [word_t]; // keyed by byte address, grows on demand
	prediction_t expected;
	word_t       expectedPc;
	int          cycleCount = 0;
	int          retired;
	string       testName;

	funct_e  knownFuncts [5] = '{fnAdd, fnSub, fnAnd, fnOr, fnSlt};
	opCode_e knownOps [5]    = '{opRType, opAddi, opLw, opSw, opBeq};

	mipsCore #(
		.DATA_WORDS (DATA_WORDS)
	) mipsCore_i (
		.clk      (clk),
		.reset    (reset),
		.pc       (pc),
		.instr    (instr),
		.regWe    (regWe),
		.regWaddr (regWaddr),
		.regWdata (regWdata),
		.memWe    (memWe),
		.memWaddr (memWaddr),
		.memWdata (memWdata)
	);

	initial clk = 1'b0;
	always #(HALF_PERIOD) clk = ~clk;

	task automatic stopRun(string reason);
		$display("Finished with errors");
		$fatal(1, "%s", reason);
	endtask

	always @(posedge clk) begin
		cycleCount = cycleCount + 1;
		if (cycleCount >= TIMEOUT_CYCLES) begin
			$display("timeout: the run did not complete within %0d cycles", TIMEOUT_CYCLES);
			stopRun("timeout");
		end
	end

	function automatic word_t encodeR(logic [5:0] fn, regAddr_t rs, regAddr_t rt, regAddr_t rd);
		return {6'h00, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic word_t encodeI(logic [5:0] op, regAddr_t rs, regAddr_t rt, logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic regAddr_t randomReg();
		return regAddr_t'($urandom_range(0, 7)); // few registers so values collide
	endfunction

	function automatic bit isKnownFunct(logic [5:0] code);
		foreach (knownFuncts[i]) begin
			if (code == knownFuncts[i]) begin
				return 1'b1;
			end
		end
		return 1'b0;
	endfunction

	function automatic bit isKnownOp(logic [5:0] code);
		foreach (knownOps[i]) begin
			if (code == knownOps[i]) begin
				return 1'b1;
			end
		end
		return 1'b0;
	endfunction

	// small word offset on r0, sometimes one memory length further to alias
	function automatic logic [15:0] memOffset();
		logic [15:0] offset;
		offset = 16'($urandom_range(0, 15) * 4);
		if ($urandom_range(0, 3) == 0) begin
			offset = offset + 16'(DATA_WORDS * 4);
		end
		return offset;
	endfunction

	function automatic word_t unknownOpInstr();
		logic [5:0] code;
		do begin
			code = 6'($urandom_range(1, 63));
		end while (isKnownOp(code));
		return encodeI(code, randomReg(), randomReg(), 16'($urandom()));
	endfunction

	// branches here only go forward, loops come from generateProgram
	function automatic word_t randomInstr();
		int unsigned pick;
		logic [5:0]  code;
		pick = $urandom_range(0, 99);
		if (pick < 35) begin
			code = knownFuncts[$urandom_range(0, 4)];
			return encodeR(code, randomReg(), randomReg(), randomReg());
		end else if (pick < 50) begin
			return encodeI(opAddi, randomReg(), randomReg(), 16'($urandom()));
		end else if (pick < 65) begin
			return encodeI(opLw, '0, randomReg(), memOffset());
		end else if (pick < 80) begin
			return encodeI(opSw, '0, randomReg(), memOffset());
		end else if (pick < 90) begin
			return encodeI(opBeq, randomReg(), randomReg(), 16'($urandom_range(0, 3)));
		end else if (pick < 95) begin
			do begin
				code = 6'($urandom());
			end while (isKnownFunct(code));
			return encodeR(code, randomReg(), randomReg(), randomReg()); // bad funct
		end
		return unknownOpInstr();
	endfunction

	task automatic generateProgram();
		regAddr_t counter;
		regAddr_t other;
		int       offset;
		progMem.delete();
		for (int i = 0; i < PROG_LEN; i++) begin
			progMem[word_t'(i * 4)] = randomInstr();
		end
		// backward beq groups, the counter steps each pass so the loop exits
		for (int i = 3; i < PROG_LEN; i++) begin
			if ($urandom_range(0, 99) < 5) begin
				counter = regAddr_t'($urandom_range(1, 7));
				do begin
					other = randomReg();
				end while (other == counter);
				offset = -int'($urandom_range(2, 3));
				if (offset == -3) begin
					progMem[word_t'((i - 2) * 4)] = encodeI(opSw, '0, randomReg(), memOffset());
				end
				progMem[word_t'((i - 1) * 4)] = encodeI(opAddi, counter, counter, 16'd1);
				progMem[word_t'(i * 4)]       = encodeI(opBeq, counter, other, 16'(offset));
			end
		end
		progMem[word_t'(0)] = unknownOpInstr(); // first retired instruction writes nothing
	endtask

	function automatic word_t fetchInstr(word_t addr);
		if (!progMem.exists(addr)) begin
			progMem[addr] = randomInstr(); // outside the program
		end
		return progMem[addr];
	endfunction

	function automatic string instrName(word_t w);
		case (w[31:26])
			opRType: begin
				case (w[5:0])
					fnAdd:   return "add";
					fnSub:   return "sub";
					fnAnd:   return "and";
					fnOr:    return "or";
					fnSlt:   return "slt";
					default: return "badFunct";
				endcase
			end
			opAddi:  return "addi";
			opLw:    return "lw";
			opSw:    return "sw";
			opBeq:   return "beq";
			default: return "badOpcode";
		endcase
	endfunction

	task automatic checkPc(string name, word_t expPc);
		if (pc !== expPc) begin
			$display("error %s: pc expected %h, actual %h", name, expPc, pc);
			stopRun("pc mismatch");
		end
	endtask

	task automatic checkRegWrite(string name, logic expWe, regAddr_t expAddr, word_t expData);
		if (regWe !== expWe) begin
			$display("error %s: regWe expected %0b, actual %0b", name, expWe, regWe);
			stopRun("register write enable mismatch");
		end
		if (expWe && ((regWaddr !== expAddr) || (regWdata !== expData))) begin
			$display("error %s: register write expected r%0d=%h, actual r%0d=%h",
				name, expAddr, expData, regWaddr, regWdata);
			stopRun("register write mismatch");
		end
	endtask

	task automatic checkMemWrite(string name, logic expWe, word_t expAddr, word_t expData);
		if (memWe !== expWe) begin
			$display("error %s: memWe expected %0b, actual %0b", name, expWe, memWe);
			stopRun("memory write enable mismatch");
		end
		if (expWe && ((memWaddr !== expAddr) || (memWdata !== expData))) begin
			$display("error %s: memory write expected [%h]=%h, actual [%h]=%h",
				name, expAddr, expData, memWaddr, memWdata);
			stopRun("memory write mismatch");
		end
	endtask

	initial begin
		void'($urandom(SEED));
		reset = 1'b1;
		instr = '0;
		generateProgram();
		resetState(DATA_WORDS);
		@(posedge clk);
		repeat (RESET_CYCLES - 1) begin
			#(DRIVE_DELAY);
			instr = randomInstr(); // anything, reset gates the writes
			#(CHECK_AT);
			checkPc("reset", '0);
			checkRegWrite("reset", 1'b0, '0, '0);
			checkMemWrite("reset", 1'b0, '0, '0);
			@(posedge clk);
		end
		#(DRIVE_DELAY);
		reset = 1'b0; // eighth edge done
		retired = 0;
		while (retired < RUN_LENGTH) begin
			expectedPc = archPc;
			instr      = fetchInstr(pc); // served from the pc the DUT presents
			testName   = instrName(instr);
			expected   = execute(instr);
			#(CHECK_AT);
			checkPc(testName, expectedPc);
			checkRegWrite(testName, expected.regWe, expected.regWaddr, expected.regWdata);
			checkMemWrite(testName, expected.memWe, expected.memWaddr, expected.memWdata);
			retired = retired + 1;
			@(posedge clk);
			#(DRIVE_DELAY);
		end
		$display("Finished with no errors");
		$finish;
	end

endmodule

// ==== vlog.f ====
logic/mipsIsaPkg.sv
logic/mipsCtrlPkg.sv
logic/controlUnit.sv
logic/aluUnit.sv
logic/regFile.sv
logic/dataMemory.sv
logic/mipsCore.sv
bench/mipsModel.sv
bench/coreBench.sv

// ==== Bender.yml ====
package:
  name: mips_core

sources:
  - files:
      - logic/mipsIsaPkg.sv
      - logic/mipsCtrlPkg.sv
      - logic/controlUnit.sv
      - logic/aluUnit.sv
      - logic/regFile.sv
      - logic/dataMemory.sv
      - logic/mipsCore.sv
  - target: test
    files:
      - bench/mipsModel.sv
      - bench/coreBench.sv
